// ==== stream_pkg.sv ====
package stream_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Datapath types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic signed [15:0] sample_t;   // Stream sample
   typedef logic [15:0]        gain_t;     // Unsigned Q8.8, 256 is unity
   typedef logic signed [15:0] offset_t;   // Added after scaling
   typedef logic [31:0]        count_t;    // Status counters wrap

   localparam gain_t gain_unity = 16'd256;

   typedef struct packed {
      logic    enable;
      gain_t   gain;
      offset_t offset;
   } stream_cfg_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // AXI4-Lite register port
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic [7:0]  axil_addr_t;
   typedef logic [31:0] axil_data_t;
   typedef logic [1:0]  axil_resp_t;

   localparam axil_resp_t resp_okay   = 2'b00;
   localparam axil_resp_t resp_slverr = 2'b10;

   // Signals driven by the master
   typedef struct packed {
      logic       aw_valid;
      axil_addr_t aw_addr;
      logic       w_valid;
      axil_data_t w_data;
      logic       b_ready;
      logic       ar_valid;
      axil_addr_t ar_addr;
      logic       r_ready;
   } axil_req_t;

   // Signals driven by the slave
   typedef struct packed {
      logic       aw_ready;
      logic       w_ready;
      logic       b_valid;
      axil_resp_t b_resp;
      logic       ar_ready;
      logic       r_valid;
      axil_data_t r_data;
      axil_resp_t r_resp;
   } axil_rsp_t;

   // Register map, byte addresses
   localparam axil_addr_t addr_ctrl       = 8'h00;   // Bit 0 is enable
   localparam axil_addr_t addr_gain       = 8'h04;
   localparam axil_addr_t addr_offset     = 8'h08;
   localparam axil_addr_t addr_sample_cnt = 8'h0C;   // Read only
   localparam axil_addr_t addr_sat_cnt    = 8'h10;   // Read only

endpackage

// ==== dti.sv ====
`timescale 1ns/1ps

// Valid/ready sample stream. A transfer happens on every edge where
// valid and ready are both high
interface dti;
   import stream_pkg::*;

   sample_t data;
   logic    valid;
   logic    ready;

   modport producer (
      output data,
      output valid,
      input  ready
   );

   modport consumer (
      input  data,
      input  valid,
      output ready
   );

endinterface

// ==== decoupler.sv ====
`timescale 1ns/1ps

module decoupler #(
   parameter int DEPTH = 2
) (
   input logic  clk,
   input logic  rst,
   dti.consumer din,
   dti.producer dout
);
   import stream_pkg::*;

   logic full;   // No room for another sample

   if (DEPTH > 1) begin : g_fifo

      localparam int AW = $clog2(DEPTH);

      logic [AW:0] w_ptr;   // Extra top bit tells full from empty
      logic [AW:0] r_ptr;
      logic [AW:0] fill;    // Samples held, from the pointer distance
      logic        empty;
      sample_t     mem [DEPTH];

      assign empty = (w_ptr == r_ptr);
      assign full  = (w_ptr[AW-1:0] == r_ptr[AW-1:0]) && (w_ptr[AW] != r_ptr[AW]);
      assign fill  = w_ptr - r_ptr;

      always_ff @(posedge clk) begin
         if (rst) begin
            w_ptr <= '0;
         end else if (din.valid && !full) begin
            w_ptr <= w_ptr + 1'b1;
         end
      end

      always_ff @(posedge clk) begin
         if (din.valid && !full) begin
            mem[w_ptr[AW-1:0]] <= din.data;
         end
      end

      always_ff @(posedge clk) begin
         if (rst) begin
            r_ptr <= '0;
         end else if (dout.ready && !empty) begin
            r_ptr <= r_ptr + 1'b1;
         end
      end

      assign din.ready  = !full;
      assign dout.data  = mem[r_ptr[AW-1:0]];
      assign dout.valid = !empty;

      // Pointer wrap relies on the address range matching the depth
      if ((1 << AW) != DEPTH)
         $error("decoupler: DEPTH must be a power of two");

      // Occupancy never exceeds the depth, so no write lands on a full buffer
      a_no_overflow: assert property (@(posedge clk) disable iff (rst) fill <= DEPTH);

   end else begin : g_reg

      sample_t hold_data;
      logic    hold_valid;

      assign full = hold_valid;

      // Takes a new sample only once the old one has left
      always_ff @(posedge clk) begin
         if (rst) begin
            hold_valid <= 1'b0;
         end else if (hold_valid) begin
            if (dout.ready) hold_valid <= 1'b0;
         end else begin
            hold_valid <= din.valid;
         end
      end

      always_ff @(posedge clk) begin
         if (!hold_valid) hold_data <= din.data;
      end

      assign din.ready  = !hold_valid;
      assign dout.data  = hold_data;
      assign dout.valid = hold_valid;

   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Protocol checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   a_hold_stable: assert property (@(posedge clk) disable iff (rst)
      dout.valid && !dout.ready |=> dout.valid && $stable(dout.data));

endmodule

// ==== gain_stage.sv ====
`timescale 1ns/1ps

module gain_stage (
   input  logic                    clk,
   input  logic                    rst,
   input  stream_pkg::stream_cfg_t cfg,
   dti.consumer                    din,
   dti.producer                    dout,
   output logic                    sat_pulse
);
   import stream_pkg::*;

   localparam logic signed [25:0] sum_max = 26'sd32767;
   localparam logic signed [25:0] sum_min = -26'sd32768;

   logic signed [16:0] gain_s;     // Gain with a zero sign bit
   logic signed [32:0] product;
   logic signed [32:0] shifted;
   logic signed [25:0] sum;        // Wide enough for any scaled value plus offset
   sample_t            result;
   logic               result_sat;
   sample_t            out_data;
   logic               out_valid;
   logic               out_sat;
   logic               accept;

   assign din.ready = !out_valid || dout.ready;   // Empty, or emptying this cycle
   assign accept    = din.valid && din.ready;

   always_comb begin
      gain_s     = {1'b0, cfg.gain};
      product    = 33'(din.data) * 33'(gain_s);
      shifted    = product >>> 8;   // Drop the Q8.8 fraction
      sum        = $signed(shifted[25:0]) + 26'(cfg.offset);
      result     = din.data;
      result_sat = 1'b0;
      if (cfg.enable) begin
         if (sum > sum_max) begin
            result     = 16'sh7FFF;
            result_sat = 1'b1;
         end else if (sum < sum_min) begin
            result     = -16'sh8000;
            result_sat = 1'b1;
         end else begin
            result = sum[15:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (accept) begin
         out_valid <= 1'b1;
      end else if (dout.ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         out_data <= result;
         out_sat  <= result_sat;
      end
   end

   assign dout.data  = out_data;
   assign dout.valid = out_valid;
   assign sat_pulse  = out_valid && dout.ready && out_sat;   // One per clamped transfer

   // A clamped transfer leaves on one of the two rails
   a_sat_on_transfer: assert property (@(posedge clk) disable iff (rst)
      sat_pulse |-> dout.valid && dout.ready
                    && (dout.data == 16'sh7FFF || dout.data == 16'sh8000));

endmodule

// ==== stream_ctrl.sv ====
`timescale 1ns/1ps

module stream_ctrl (
   input  logic                    clk,
   input  logic                    rst,
   input  stream_pkg::axil_req_t   axil_req,
   output stream_pkg::axil_rsp_t   axil_rsp,
   output stream_pkg::stream_cfg_t cfg,
   input  logic                    out_fire,
   input  logic                    sat_pulse
);
   import stream_pkg::*;

   typedef enum logic {w_idle, w_resp} write_state_t;
   typedef enum logic {r_idle, r_resp} read_state_t;

   write_state_t w_state;
   read_state_t  r_state;
   stream_cfg_t  cfg_q;
   count_t       sample_cnt;
   count_t       sat_cnt;
   logic         wr_accept;
   logic         rd_accept;
   logic         wr_mapped;
   logic         rd_mapped;
   axil_data_t   rd_word;
   axil_resp_t   b_resp_q;
   axil_resp_t   r_resp_q;
   axil_data_t   r_data_q;

   // Address and data are taken together, one transaction at a time
   assign wr_accept = (w_state == w_idle) && axil_req.aw_valid && axil_req.w_valid;
   assign rd_accept = (r_state == r_idle) && axil_req.ar_valid;

   // Only the configuration registers are writable
   assign wr_mapped = (axil_req.aw_addr == addr_ctrl) || (axil_req.aw_addr == addr_gain)
                      || (axil_req.aw_addr == addr_offset);

   always_comb begin
      rd_mapped = 1'b1;
      case (axil_req.ar_addr)
         addr_ctrl:       rd_word = {31'b0, cfg_q.enable};
         addr_gain:       rd_word = {16'b0, cfg_q.gain};
         addr_offset:     rd_word = 32'(cfg_q.offset);   // Sign extended
         addr_sample_cnt: rd_word = sample_cnt;
         addr_sat_cnt:    rd_word = sat_cnt;
         default: begin
            rd_word   = '0;
            rd_mapped = 1'b0;
         end
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Write channel and configuration registers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (rst) begin
         w_state      <= w_idle;
         cfg_q.enable <= 1'b0;
         cfg_q.gain   <= gain_unity;
         cfg_q.offset <= '0;
      end else begin
         case (w_state)
            w_idle: if (wr_accept) begin
               w_state  <= w_resp;
               b_resp_q <= wr_mapped ? resp_okay : resp_slverr;
               case (axil_req.aw_addr)
                  addr_ctrl:   cfg_q.enable <= axil_req.w_data[0];
                  addr_gain:   cfg_q.gain   <= axil_req.w_data[15:0];
                  addr_offset: cfg_q.offset <= axil_req.w_data[15:0];
                  default:     ;   // Read-only or unmapped, nothing changes
               endcase
            end
            w_resp: if (axil_req.b_ready) w_state <= w_idle;
            default: w_state <= w_idle;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Read channel and status counters
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (rst) begin
         r_state <= r_idle;
      end else begin
         case (r_state)
            r_idle: if (rd_accept) begin
               r_state  <= r_resp;
               r_data_q <= rd_word;   // Snapshot at acceptance
               r_resp_q <= rd_mapped ? resp_okay : resp_slverr;
            end
            r_resp: if (axil_req.r_ready) r_state <= r_idle;
            default: r_state <= r_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         sample_cnt <= '0;
         sat_cnt    <= '0;
      end else begin
         if (out_fire)  sample_cnt <= sample_cnt + 1'b1;
         if (sat_pulse) sat_cnt    <= sat_cnt + 1'b1;
      end
   end

   assign cfg = cfg_q;

   assign axil_rsp.aw_ready = wr_accept;
   assign axil_rsp.w_ready  = wr_accept;
   assign axil_rsp.b_valid  = (w_state == w_resp);
   assign axil_rsp.b_resp   = b_resp_q;
   assign axil_rsp.ar_ready = (r_state == r_idle);
   assign axil_rsp.r_valid  = (r_state == r_resp);
   assign axil_rsp.r_data   = r_data_q;
   assign axil_rsp.r_resp   = r_resp_q;

   // A response must follow a handshake seen at the port one cycle earlier
   a_b_after_req: assert property (@(posedge clk) disable iff (rst)
      $rose(axil_rsp.b_valid) |-> $past(axil_req.aw_valid && axil_rsp.aw_ready
                                        && axil_req.w_valid && axil_rsp.w_ready));

   a_r_after_req: assert property (@(posedge clk) disable iff (rst)
      $rose(axil_rsp.r_valid) |-> $past(axil_req.ar_valid && axil_rsp.ar_ready));

endmodule

// ==== stream_top.sv ====
`timescale 1ns/1ps

module stream_top #(
   parameter int IN_DEPTH  = 4,
   parameter int OUT_DEPTH = 2
) (
   input  logic                  clk,
   input  logic                  rst,
   input  stream_pkg::axil_req_t axil_req,
   output stream_pkg::axil_rsp_t axil_rsp,
   dti.consumer                  s_in,
   dti.producer                  s_out
);
   import stream_pkg::*;

   stream_cfg_t cfg;
   logic        sat_pulse;
   logic        out_fire;   // Sample leaves the subsystem

   dti in_to_gain ();
   dti gain_to_out ();

   assign out_fire = s_out.valid && s_out.ready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Register block
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   stream_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .axil_req  (axil_req),
      .axil_rsp  (axil_rsp),
      .cfg       (cfg),
      .out_fire  (out_fire),
      .sat_pulse (sat_pulse)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Sample path, three registered stages
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   decoupler #(.DEPTH(IN_DEPTH)) u_in_dec (
      .clk  (clk),
      .rst  (rst),
      .din  (s_in),
      .dout (in_to_gain)
   );

   gain_stage u_gain (
      .clk       (clk),
      .rst       (rst),
      .cfg       (cfg),
      .din       (in_to_gain),
      .dout      (gain_to_out),
      .sat_pulse (sat_pulse)
   );

   decoupler #(.DEPTH(OUT_DEPTH)) u_out_dec (
      .clk  (clk),
      .rst  (rst),
      .din  (gain_to_out),
      .dout (s_out)
   );

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
   input  logic                  clk,
   input  logic                  rst,
   input  stream_pkg::axil_req_t axil_req,
   input  stream_pkg::axil_rsp_t axil_rsp,
   input  stream_pkg::sample_t   out_data,
   input  logic                  out_valid,
   input  logic                  out_ready,
   output int                    pending,
   output logic                  any_fail
);
   import stream_pkg::*;

   sample_t    exp_samples [$];
   axil_resp_t exp_b_resp [$];
   axil_data_t exp_r_data [$];
   axil_resp_t exp_r_resp [$];

   int    n_queued     = 0;
   int    n_seen       = 0;
   int    total_errs   = 0;
   int    test_errs    = 0;
   int    test_checks  = 0;
   int    tests_passed = 0;
   int    tests_failed = 0;
   string test_name    = "";

   assign pending  = n_queued - n_seen;
   assign any_fail = (total_errs != 0);

   task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] act);
      test_checks++;
      if (exp !== act) begin
         $display("FAIL %0t %s expected %0h actual %0h", $time, sig, exp, act);
         test_errs++;
         total_errs++;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("Error at %0t: %s", $time, msg);
      test_errs++;
      total_errs++;
   endtask

   task automatic expect_sample(input sample_t v);
      exp_samples.push_back(v);
      n_queued++;
   endtask

   task automatic expect_write(input axil_resp_t r);
      exp_b_resp.push_back(r);
   endtask

   task automatic expect_read(input axil_data_t d, input axil_resp_t r);
      exp_r_data.push_back(d);
      exp_r_resp.push_back(r);
   endtask

   task automatic close_test;
      if (test_name != "") begin
         if (test_errs == 0) begin
            tests_passed++;
            $display("TEST %s passed, %0d checks", test_name, test_checks);
         end else begin
            tests_failed++;
            $display("TEST %s failed, %0d errors in %0d checks", test_name, test_errs,
                     test_checks);
         end
      end
      test_errs   = 0;
      test_checks = 0;
   endtask

   task automatic begin_test(input string name);
      close_test();
      test_name = name;
   endtask

   task automatic end_run;
      close_test();
      $display("Tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed,
               total_errs);
   endtask

   // Transfers are seen at the rising edge where valid and ready are both high
   always @(posedge clk) begin
      if (!rst) begin
         if (out_valid && out_ready) begin
            if (exp_samples.size() == 0) begin
               note_failure("an output sample came out with none expected");
            end else begin
               compare("s_out.data", exp_samples.pop_front(), out_data);
               n_seen++;
            end
         end
         // Address and data of a write are taken in the same cycle
         if (axil_rsp.aw_ready || axil_rsp.w_ready) begin
            compare("w_ready", axil_rsp.aw_ready, axil_rsp.w_ready);
         end
         if (axil_rsp.b_valid && axil_req.b_ready) begin
            if (exp_b_resp.size() == 0) note_failure("write response without a write");
            else compare("b_resp", exp_b_resp.pop_front(), axil_rsp.b_resp);
         end
         if (axil_rsp.r_valid && axil_req.r_ready) begin
            if (exp_r_data.size() == 0) begin
               note_failure("read response without a read");
            end else begin
               compare("r_data", exp_r_data.pop_front(), axil_rsp.r_data);
               compare("r_resp", exp_r_resp.pop_front(), axil_rsp.r_resp);
            end
         end
      end
   end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
   import stream_pkg::*;

   localparam int IN_DEPTH   = 4;
   localparam int OUT_DEPTH  = 2;
   localparam int wait_limit = 2000;   // Cycles before any single wait gives up

   typedef enum {on_in_ready, on_aw_ready, on_b_valid, on_ar_ready, on_r_valid, on_in_full}
      watch_t;

   logic      clk;
   logic      rst;
   axil_req_t axil_req;
   axil_rsp_t axil_rsp;
   logic      hold_out;   // Forces output ready low for the fill test
   logic      aborted;    // Set when a wait runs out, stops the vector loop
   int        seed;
   int        pending;    // Expected samples not yet seen at the output
   logic      any_fail;

   dti s_in ();
   dti s_out ();

   stream_top #(
      .IN_DEPTH  (IN_DEPTH),
      .OUT_DEPTH (OUT_DEPTH)
   ) u_stream_top (
      .clk      (clk),
      .rst      (rst),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .s_in     (s_in),
      .s_out    (s_out)
   );

   tb_checker u_checker (
      .clk       (clk),
      .rst       (rst),
      .axil_req  (axil_req),
      .axil_rsp  (axil_rsp),
      .out_data  (s_out.data),
      .out_valid (s_out.valid),
      .out_ready (s_out.ready),
      .pending   (pending),
      .any_fail  (any_fail)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Random back-pressure, a new ready value at every falling edge
   initial begin
      int rnd;
      seed        = 32'hae8c769a;
      s_out.ready = 1'b0;
      forever begin
         @(negedge clk);
         rnd         = $random(seed);
         s_out.ready = !hold_out && rnd[0];
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Handshake helpers, each entered and left at a falling edge
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // The watched value is taken at the rising edge, before the DUT updates
   task automatic wait_for(input watch_t what, input string msg);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && !aborted) begin
         @(posedge clk);
         case (what)
            on_in_ready: seen = s_in.ready;
            on_aw_ready: seen = axil_rsp.aw_ready;
            on_b_valid:  seen = axil_rsp.b_valid;
            on_ar_ready: seen = axil_rsp.ar_ready;
            on_r_valid:  seen = axil_rsp.r_valid;
            default:     seen = !s_in.ready;
         endcase
         n++;
         if (!seen && n >= wait_limit) begin
            u_checker.note_failure({"timeout, ", msg});
            aborted = 1'b1;
         end
      end
      @(negedge clk);
   endtask

   task automatic drain;
      int n;
      n = 0;
      while (pending != 0 && !aborted) begin
         @(negedge clk);
         n++;
         if (n >= wait_limit) begin
            u_checker.note_failure("timeout, expected samples never left the DUT");
            aborted = 1'b1;
         end
      end
   endtask

   task automatic push_sample(input sample_t v);
      s_in.data  = v;
      s_in.valid = 1'b1;
      wait_for(on_in_ready, "input ready stayed low");
      s_in.valid = 1'b0;
   endtask

   task automatic reg_write(input axil_addr_t a, input axil_data_t d, input axil_resp_t r);
      u_checker.expect_write(r);
      axil_req.aw_addr  = a;
      axil_req.w_data   = d;
      axil_req.aw_valid = 1'b1;
      axil_req.w_valid  = 1'b1;
      wait_for(on_aw_ready, "write address was never accepted");
      axil_req.aw_valid = 1'b0;
      axil_req.w_valid  = 1'b0;
      wait_for(on_b_valid, "no write response");   // b_ready stays high
   endtask

   task automatic reg_read(input axil_addr_t a, input axil_data_t d, input axil_resp_t r);
      u_checker.expect_read(d, r);
      axil_req.ar_addr  = a;
      axil_req.ar_valid = 1'b1;
      wait_for(on_ar_ready, "read address was never accepted");
      axil_req.ar_valid = 1'b0;
      wait_for(on_r_valid, "no read response");
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Golden file reader
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin
      int         fd;
      int         sin;
      int         sout;
      string      line;
      string      cmd;
      string      name;
      axil_addr_t addr_v;
      axil_data_t data_v;
      axil_resp_t resp_v;
      axil_req          = '0;
      axil_req.b_ready  = 1'b1;
      axil_req.r_ready  = 1'b1;
      s_in.data         = '0;
      s_in.valid        = 1'b0;
      hold_out          = 1'b0;
      aborted           = 1'b0;
      rst               = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      fd = $fopen("golden_vectors.txt", "r");
      if (fd == 0) begin
         u_checker.note_failure("golden_vectors.txt could not be opened");
         aborted = 1'b1;
      end
      while (!aborted && !$feof(fd)) begin
         line = "";
         cmd  = "";
         if ($fgets(line, fd) == 0) continue;
         if ($sscanf(line, "%s", cmd) != 1 || cmd == "#") continue;
         if (cmd == "T") begin
            void'($sscanf(line, "%s %s", cmd, name));
            u_checker.begin_test(name);
         end else if (cmd == "S") begin
            void'($sscanf(line, "%s %d %d", cmd, sin, sout));
            u_checker.expect_sample(sample_t'(sout));
            push_sample(sample_t'(sin));
         end else if (cmd == "W") begin
            void'($sscanf(line, "%s %h %h %h", cmd, addr_v, data_v, resp_v));
            drain();   // Register changes only between sample bursts
            reg_write(addr_v, data_v, resp_v);
         end else if (cmd == "R") begin
            void'($sscanf(line, "%s %h %h %h", cmd, addr_v, data_v, resp_v));
            drain();
            reg_read(addr_v, data_v, resp_v);
         end else if (cmd == "H") begin
            hold_out <= 1'b1;
         end else if (cmd == "G") begin
            hold_out <= 1'b0;
         end else if (cmd == "F") begin
            wait_for(on_in_full, "input ready never fell with the output blocked");
         end else begin
            u_checker.note_failure({"unknown line in golden file: ", line});
         end
      end
      if (fd != 0) $fclose(fd);
      if (!aborted) drain();
      u_checker.end_run();

      if (any_fail || aborted) begin
         $display("*** FAILED ***");
      end else begin
         $display("*** PASSED ***");
      end
      $finish;
   end

endmodule

// ==== golden_vectors.txt ====
# T name | W addr data resp | R addr data resp (hex) | S in out (decimal)
# H holds output ready low, F waits for input ready to fall, G releases output ready
T reset_values
R 00 00000000 0
R 04 00000100 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
T bypass
S 100 100
S -200 -200
S 32767 32767
S -32768 -32768
S 5 5
S 0 0
T scaling
W 00 00000001 0
W 04 00000180 0
W 08 FFFFFF9C 0
R 08 FFFFFF9C 0
S 100 50
S -100 -250
S 1 -99
S -1 -102
S 1000 1400
S 7 -90
S -7 -111
T saturation
S 30000 32767
S -30000 -32768
S 21900 32750
S 22000 32767
S -21800 -32768
R 10 00000004 0
R 0C 00000012 0
T error_resp
W 0C 00000055 2
W 20 00000001 2
R 20 00000000 2
R 0C 00000012 0
R 10 00000004 0
R 00 00000001 0
T backpressure
W 00 00000000 0
H
S 11 11
S 12 12
S 13 13
S 14 14
S 15 15
S 16 16
S 17 17
F
G
S 18 18
S 19 19
R 0C 0000001B 0
R 10 00000004 0

// ==== vlog.f ====
stream_pkg.sv
dti.sv
decoupler.sv
gain_stage.sv
stream_ctrl.sv
stream_top.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
# Verilator build and run for the sample-stream testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
